//--- compile.f
+incdir+design
design/iram_pkg.sv
design/iram_dpram.sv
design/iram_loader.sv
design/iram_fetch_seq.sv
design/iram_top.sv
tb/tb_iram_top.sv

//--- Bender.yml
package:
  name: iram

sources:
  - include_dirs:
      - design
    files:
      - design/iram_pkg.sv
      - design/iram_dpram.sv
      - design/iram_loader.sv
      - design/iram_fetch_seq.sv
      - design/iram_top.sv
  - target: test
    include_dirs:
      - design
    files:
      - tb/tb_iram_top.sv

//--- tb/tb_iram_top.sv
// Testbench for the instruction store: stimulus, shadow memory, reference model and result checks
`timescale 1ns/1ns
`include "iram_consts.svh"

module tb_iram_top;

   import iram_pkg::*;

   localparam int BLOCK       = 64;
   localparam int PHASE_TOTAL = 12 + 140 + 40 + 30 + 40;  // Reset, load, fetch, wrap, restart
   localparam int CYCLE_LIMIT = 2 * PHASE_TOTAL;

   logic        clk_a = 1'b0;
   logic        reset = 1'b1;
   logic        load_start = 1'b0, load_valid = 1'b0, host_rd = 1'b0;
   logic        run = 1'b0, halt = 1'b0;
   iram_addr_t  load_addr = '0, host_addr = '0, start_pc = '0;
   iram_word_t  load_data = '0;
   iram_word_t  host_q;
   logic        host_q_valid, fetch_valid;
   iram_fetch_t fetch_out;

   iram_word_t  shadow [`IRAM_DEPTH];        // Mirrors every word the tests load
   iram_addr_t  cursor_model = '0;
   iram_addr_t  exp_pc [$];
   logic [31:0] lfsr = 32'h5430dff8;
   logic        rd_pending = 1'b0;
   iram_word_t  rd_expect;
   iram_addr_t  stale_pc, base;
   logic        stale_valid = 1'b0;
   iram_word_t  stale_word;
   int          fetch_total = 0, after_halt = 0, cycles = 0;

   iram_top dut_i (.*);

   always #10 clk_a = ~clk_a;

   // ########################################################################
   // Reference model and helpers
   // ########################################################################

   function automatic iram_addr_t next_addr(input iram_addr_t a);
      return (a == iram_addr_t'(`IRAM_DEPTH - 1)) ? '0 : iram_addr_t'(a + 1);
   endfunction

   // Fibonacci LFSR, taps 32 22 2 1, one step per bit taken
   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] r;
      logic        fb;
      r = '0;
      for (int i = 0; i < n; i++)
      begin
         fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
         lfsr = {lfsr[30:0], fb};
         r    = {r[30:0], fb};
      end
      return r;
   endfunction

   function automatic iram_word_t expected_word(input iram_addr_t addr);
      return shadow[addr];
   endfunction

   task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
      if (got !== exp)
      begin
         $display("MISMATCH %s got %0h expected %0h", name, got, exp);
         $display("test failed");
         $fatal(1);
      end
   endtask

   task automatic abort_run(input string what);
      $display("ERROR %s", what);
      $display("test failed");
      $fatal(1);
   endtask

   // Keeps the first entries still in flight and appends the new pc sequence
   task automatic fill_pc_queue(input iram_addr_t pc, input int keep);
      while (exp_pc.size() > keep)
         exp_pc.delete(exp_pc.size() - 1);
      repeat (BLOCK)
      begin
         exp_pc.push_back(pc);
         pc = next_addr(pc);
      end
   endtask

   // ########################################################################
   // Result checking, sampled mid-cycle
   // ########################################################################

   always @(negedge clk_a)
   begin : compare
      iram_addr_t pc_exp;
      iram_word_t word_exp;
      if (reset)
      begin
         check("host_q_valid", host_q_valid, 1'b0);
         check("fetch_valid", fetch_valid, 1'b0);
      end
      else
      begin
         check("host_q_valid", host_q_valid, rd_pending);  // Exactly one cycle after host_rd
         if (host_q_valid)
            check("host_q", host_q, rd_expect);
         if (fetch_valid && exp_pc.size() == 0)
            abort_run("fetch result appeared while no fetch was expected");
         else if (fetch_valid)
         begin
            pc_exp = exp_pc.pop_front();
            if (stale_valid && pc_exp == stale_pc)
            begin
               word_exp    = stale_word;           // Mixed-port read sees the old word
               stale_valid = 1'b0;
            end
            else
               word_exp = expected_word(pc_exp);
            check("fetch_out.pc", fetch_out.pc, pc_exp);
            check("fetch_out.word", fetch_out.word, word_exp);
            fetch_total++;
            after_halt++;
         end
      end
      rd_pending = host_rd;
      rd_expect  = expected_word(host_addr);
   end

   always @(posedge clk_a)
   begin
      cycles++;
      if (cycles > CYCLE_LIMIT)
      begin
         $display("ERROR run did not finish within %0d cycles", CYCLE_LIMIT);
         $display("test failed");
         $fatal(1);
      end
   end

   // ########################################################################
   // Stimulus
   // ########################################################################

   task automatic clear_strobes();
      load_start <= 1'b0;
      load_valid <= 1'b0;
      host_rd    <= 1'b0;
      run        <= 1'b0;
      halt       <= 1'b0;
   endtask

   task automatic idle(input int n);
      repeat (n)
      begin
         @(posedge clk_a);
         clear_strobes();
      end
   endtask

   task automatic load_word(input logic start, input iram_addr_t addr, input iram_word_t data);
      @(posedge clk_a);
      clear_strobes();
      load_start <= start;
      load_addr  <= addr;
      load_valid <= 1'b1;
      load_data  <= data;
      if (start)
         cursor_model = addr;
      shadow[cursor_model] = data;
      cursor_model = next_addr(cursor_model);   // Same wrap as the pc
   endtask

   task automatic host_read(input iram_addr_t addr);
      @(posedge clk_a);
      clear_strobes();
      host_rd   <= 1'b1;
      host_addr <= addr;
   endtask

   // On a restart the reads issued on this edge and on the edge that samples run
   // still return from the old sequence
   task automatic start_run(input iram_addr_t pc, input logic restart);
      @(posedge clk_a);
      clear_strobes();
      run      <= 1'b1;
      start_pc <= pc;
      fill_pc_queue(pc, restart ? 2 : 0);
   endtask

   task automatic stop_run();
      @(posedge clk_a);
      clear_strobes();
      halt <= 1'b1;
      @(posedge clk_a);
      clear_strobes();
      after_halt = 0;
      idle(4);
      if (after_halt > 1)
         abort_run("more than one fetch result followed a halt");
      else
         exp_pc.delete();
   endtask

   initial
   begin : stimulus
      int order [BLOCK];
      int j;
      int tmp;
      int seen;
      repeat (8) @(posedge clk_a);
      reset <= 1'b0;
      idle(2);

      // Random block, read back in shuffled order
      base = iram_addr_t'(8 + rand_bits(15) % (`IRAM_DEPTH - 80));
      load_word(1'b1, base, rand_bits(32));
      for (int i = 1; i < BLOCK; i++)
         load_word(1'b0, '0, rand_bits(32));
      for (int i = 0; i < BLOCK; i++)
         order[i] = i;
      for (int i = BLOCK - 1; i > 0; i--)
      begin
         j        = rand_bits(6) % (i + 1);
         tmp      = order[i];
         order[i] = order[j];
         order[j] = tmp;
      end
      foreach (order[i])
         host_read(base + iram_addr_t'(order[i]));
      idle(2);

      seen = fetch_total;
      start_run(base + iram_addr_t'(rand_bits(5)), 1'b0);
      idle(20);
      stop_run();
      if (fetch_total - seen < 20)
         abort_run("sequential fetch delivered fewer results than running cycles");

      // Last 4 and first 4 words through one cursor
      for (int i = 0; i < 8; i++)
         load_word(i == 0, iram_addr_t'(`IRAM_DEPTH - 4), rand_bits(32));
      seen = fetch_total;
      start_run(iram_addr_t'(`IRAM_DEPTH - 4), 1'b0);
      idle(6);
      stop_run();
      if (fetch_total - seen < 5)
         abort_run("fetch did not wrap from the last address to 0");

      start_run(base, 1'b0);
      idle(4);
      start_run(base + 15'd32, 1'b1);
      idle(3);
      stale_pc    = base + 15'd35;                 // Issued on the same edge as the write
      stale_word  = expected_word(stale_pc);
      stale_valid = 1'b1;
      load_word(1'b1, stale_pc, ~stale_word);
      idle(4);
      stop_run();
      if (stale_valid)
         abort_run("restarted fetch never reached the rewritten word");
      host_read(stale_pc);
      idle(3);

      $display("test passed");
      $finish;
   end

endmodule

//--- design/iram_top.sv
// Instruction store top level: host loader, fetch sequencer and dual-port RAM
`timescale 1ns/1ns

module iram_top
(
   input  logic                  clk_a,
   input  logic                  reset,

   // Host group
   input  logic                  load_start,
   input  iram_pkg::iram_addr_t  load_addr,
   input  logic                  load_valid,
   input  iram_pkg::iram_word_t  load_data,
   input  logic                  host_rd,
   input  iram_pkg::iram_addr_t  host_addr,
   output iram_pkg::iram_word_t  host_q,
   output logic                  host_q_valid,

   // Processor group
   input  logic                  run,
   input  iram_pkg::iram_addr_t  start_pc,
   input  logic                  halt,
   output iram_pkg::iram_fetch_t fetch_out,
   output logic                  fetch_valid
);

   import iram_pkg::*;

   iram_port_t port_a;
   iram_port_t port_b;
   iram_word_t q_a;
   iram_word_t q_b;

   iram_loader loader_i
   (
      .clk_a        (clk_a),
      .reset        (reset),
      .load_start   (load_start),
      .load_addr    (load_addr),
      .load_valid   (load_valid),
      .load_data    (load_data),
      .host_rd      (host_rd),
      .host_addr    (host_addr),
      .port_a       (port_a),
      .q_a          (q_a),
      .host_q       (host_q),
      .host_q_valid (host_q_valid)
   );

   iram_fetch_seq fetch_seq_i
   (
      .clk_a       (clk_a),
      .reset       (reset),
      .run         (run),
      .start_pc    (start_pc),
      .halt        (halt),
      .port_b      (port_b),
      .q_b         (q_b),
      .fetch_out   (fetch_out),
      .fetch_valid (fetch_valid)
   );

   iram_dpram dpram_i
   (
      .clk_a  (clk_a),
      .reset  (reset),
      .port_a (port_a),
      .port_b (port_b),
      .q_a    (q_a),
      .q_b    (q_b)
   );

endmodule

//--- design/iram_fetch_seq.sv
// Fetch sequencer for RAM port B: program counter, run/halt state, fetch result stage
`timescale 1ns/1ns
`include "iram_consts.svh"

module iram_fetch_seq
(
   input  logic                  clk_a,
   input  logic                  reset,

   input  logic                  run,
   input  iram_pkg::iram_addr_t  start_pc,
   input  logic                  halt,

   output iram_pkg::iram_port_t  port_b,
   input  iram_pkg::iram_word_t  q_b,

   output iram_pkg::iram_fetch_t fetch_out,
   output logic                  fetch_valid
);

   import iram_pkg::*;

   fetch_state_e state;
   iram_addr_t   pc;
   iram_addr_t   issued_pc;
   logic         issue;

   assign issue = (state == fetch_running);

   // ########################################################################
   // Run/halt control and program counter
   // ########################################################################

   // Halt wins over a run pulse in the same cycle
   always_ff @(posedge clk_a)
   begin
      if (reset)
         state <= fetch_halted;
      else if (halt)
         state <= fetch_halted;
      else if (run)
         state <= fetch_running;
   end

   always_ff @(posedge clk_a)
   begin
      if (reset)
         pc <= '0;
      else if (run && !halt)
         pc <= start_pc;                       // Also restarts a running sequence
      else if (issue)
         pc <= (pc == iram_addr_t'(`IRAM_DEPTH - 1)) ? '0 : pc + 1'b1;
   end

   // Read-only port
   always_comb
   begin
      port_b.addr = pc;
      port_b.data = '0;
      port_b.wren = 1'b0;
      port_b.rden = issue;
   end

   // ########################################################################
   // Fetch result stage
   // ########################################################################

   // The issued pc rides along while its word is read
   always_ff @(posedge clk_a)
   begin
      if (issue)
         issued_pc <= pc;
   end

   always_ff @(posedge clk_a)
   begin
      if (reset)
         fetch_valid <= 1'b0;
      else
         fetch_valid <= issue;
   end

   assign fetch_out.pc   = issued_pc;
   assign fetch_out.word = q_b;

   // Back-to-back results without a restart come from consecutive addresses
   a_fetch_pc_steps: assert property (@(posedge clk_a) disable iff (reset)
      (fetch_valid && $past(fetch_valid) && !$past(run, 2)) |->
         (fetch_out.pc == (($past(fetch_out.pc) == iram_addr_t'(`IRAM_DEPTH - 1)) ?
                           '0 : $past(fetch_out.pc) + 1'b1)));

endmodule

//--- design/iram_loader.sv
// Host loader for RAM port A: load cursor, write strobes and host read return
`timescale 1ns/1ns
`include "iram_consts.svh"

module iram_loader
(
   input  logic                 clk_a,
   input  logic                 reset,

   input  logic                 load_start,
   input  iram_pkg::iram_addr_t load_addr,
   input  logic                 load_valid,
   input  iram_pkg::iram_word_t load_data,
   input  logic                 host_rd,
   input  iram_pkg::iram_addr_t host_addr,

   output iram_pkg::iram_port_t port_a,
   input  iram_pkg::iram_word_t q_a,

   output iram_pkg::iram_word_t host_q,
   output logic                 host_q_valid
);

   import iram_pkg::*;

   iram_addr_t cursor;
   iram_addr_t wr_addr;
   iram_addr_t wr_addr_next;

   // A load_start in the same cycle as load_valid writes straight at load_addr
   assign wr_addr      = load_start ? load_addr : cursor;
   assign wr_addr_next = (wr_addr == iram_addr_t'(`IRAM_DEPTH - 1)) ? '0 : wr_addr + 1'b1;

   // ########################################################################
   // Load cursor
   // ########################################################################

   always_ff @(posedge clk_a)
   begin
      if (reset)
         cursor <= '0;
      else if (load_valid)
         cursor <= wr_addr_next;
      else if (load_start)
         cursor <= load_addr;
   end

   // ########################################################################
   // Port A request
   // ########################################################################

   always_comb
   begin
      port_a.data = load_data;
      port_a.wren = load_valid;
      port_a.rden = host_rd & ~load_valid;
      port_a.addr = load_valid ? wr_addr : host_addr;
   end

   // Host read data comes back on the RAM register one cycle later
   always_ff @(posedge clk_a)
   begin
      if (reset)
         host_q_valid <= 1'b0;
      else
         host_q_valid <= port_a.rden;
   end

   assign host_q = q_a;

   // Port A carries only one request per cycle
   a_no_rd_during_load: assert property (@(posedge clk_a) disable iff (reset)
      !(host_rd && load_valid));

endmodule

//--- design/iram_dpram.sv
// Dual-port 21504x32 instruction RAM with registered, write-first port outputs
`timescale 1ns/1ns
`include "iram_consts.svh"

module iram_dpram
(
   input  logic                 clk_a,
   input  logic                 reset,

   input  iram_pkg::iram_port_t port_a,
   input  iram_pkg::iram_port_t port_b,

   output iram_pkg::iram_word_t q_a,
   output iram_pkg::iram_word_t q_b
);

   import iram_pkg::*;

   iram_word_t mem [`IRAM_DEPTH];              // Contents undefined after reset

   // ########################################################################
   // Array update
   // ########################################################################

   // Reads in the same edge see the value before this update, which gives
   // old data on a mixed-port read of an address being written
   always_ff @(posedge clk_a)
   begin
      if (port_a.wren)
         mem[port_a.addr] <= port_a.data;
      if (port_b.wren)
         mem[port_b.addr] <= port_b.data;
   end

   // ########################################################################
   // Port outputs
   // ########################################################################

   always_ff @(posedge clk_a)
   begin
      if (reset)
         q_a <= '0;
      else if (port_a.wren)
         q_a <= port_a.data;                   // Write-first on its own port
      else if (port_a.rden)
         q_a <= mem[port_a.addr];
   end

   always_ff @(posedge clk_a)
   begin
      if (reset)
         q_b <= '0;
      else if (port_b.wren)
         q_b <= port_b.data;
      else if (port_b.rden)
         q_b <= mem[port_b.addr];
   end

   // The requesters compute their own wrap, so an address past the end
   // means a cursor or pc went wrong upstream
   a_port_a_in_range: assert property (@(posedge clk_a) disable iff (reset)
      (port_a.wren || port_a.rden) |-> (port_a.addr < `IRAM_DEPTH));

   a_port_b_in_range: assert property (@(posedge clk_a) disable iff (reset)
      (port_b.wren || port_b.rden) |-> (port_b.addr < `IRAM_DEPTH));

   // Loader and sequencer must not both write one word in one cycle
   a_no_write_collision: assert property (@(posedge clk_a) disable iff (reset)
      !(port_a.wren && port_b.wren && (port_a.addr == port_b.addr)));

endmodule

//--- design/iram_pkg.sv
// Instruction store types: address, word, RAM port request, fetch result, sequencer state
`include "iram_consts.svh"

package iram_pkg;

   // ########################################################################
   // Basic types
   // ########################################################################

   typedef logic [`IRAM_ADDR_W-1:0] iram_addr_t;
   typedef logic [`IRAM_WORD_W-1:0] iram_word_t;

   // ########################################################################
   // Bundles
   // ########################################################################

   // One request into a RAM port, sampled on the rising edge
   typedef struct packed {
      iram_addr_t addr;
      iram_word_t data;                        // Only meaningful with wren
      logic       wren;
      logic       rden;
   } iram_port_t;

   // One fetched instruction and the address it came from
   typedef struct packed {
      iram_addr_t pc;
      iram_word_t word;
   } iram_fetch_t;

   // Run/halt control of the fetch sequencer
   typedef enum logic {
      fetch_halted  = 1'b0,
      fetch_running = 1'b1
   } fetch_state_e;

endpackage

//--- design/iram_consts.svh
// Instruction store sizing: word count, address width and word width
`ifndef IRAM_CONSTS_SVH
`define IRAM_CONSTS_SVH

// ##########################################################################
// Store geometry
// ##########################################################################

// Words in the microcode store, 21K
`define IRAM_DEPTH 21504

// Smallest width that reaches IRAM_DEPTH-1
`define IRAM_ADDR_W 15

// One microcode word
`define IRAM_WORD_W 32

`endif
